// ==== project.f ====
source/tk1_pkg.sv
source/tk1_apb_regs.sv
source/exec_window.sv
source/security_monitor.sv
source/tk1_core.sv
dv/tk1_chk.sv
dv/tk1_tb.sv

// ==== dv/tk1_tb.sv ====
// tk1 core testbench
`timescale 1ns/1ps

module tk1_tb;

  localparam tk1_pkg::addr_t TB_APP_SIZE = 32'h00010000;
  localparam int NUM_TRIALS  = 200;
  // Fixed tests plus up to three window writes per trial
  localparam int NUM_XFERS   = 50 + 3 * NUM_TRIALS;
  localparam int WATCHDOG_NS = (NUM_XFERS + NUM_TRIALS) * 20 * 8 + 2000 * 8;

  logic clk;
  logic reset_n;
  logic syscall;
  logic force_trap, system_reset, app_mode, fw_startup_done;
  logic led_r, led_g, led_b;
  tk1_pkg::apb_req_t apb_req;
  tk1_pkg::apb_rsp_t apb_rsp;
  tk1_pkg::cpu_bus_t cpu_bus;
  tk1_pkg::addr_t    app_start, app_size;
  logic [31:0]       lfsr_state = 32'd20;

  tk1_core #(.NUM_WINDOWS(2), .APP_SIZE(TB_APP_SIZE)) UUT (
    .clk(clk), .reset_n(reset_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .cpu_bus(cpu_bus), .syscall(syscall), .force_trap(force_trap),
    .system_reset(system_reset), .app_mode(app_mode),
    .fw_startup_done(fw_startup_done), .led_r(led_r), .led_g(led_g),
    .led_b(led_b), .app_start(app_start), .app_size(app_size)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the tests did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic logic [5:0] named_sub(input logic [2:0] sel);
    logic [5:0] table_sub [8];
    table_sub = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h10, 6'h21, 6'h3f};
    return table_sub[sel];
  endfunction

  // Expected trap for one valid CPU cycle
  function automatic logic expected_trap(input logic [31:0] a, input logic is_instr,
                                         input logic app, input logic win_en,
                                         input logic [31:0] first, input logic [31:0] last);
    logic bad_map;
    logic bad_exec;
    logic in_win;
    case (a[31:30])
      2'd0: bad_map = (a[29:13] != 0);
      2'd1: bad_map = (a[29:17] != 0);
      2'd2: bad_map = 1'b1;
      default: begin
        case (a[29:24])
          6'h00, 6'h01, 6'h03, 6'h04, 6'h3f: bad_map = (a[23:10] != 0);
          6'h02:   bad_map = (a[23:5] != 0);
          6'h10:   bad_map = (a[23:12] != 0);
          6'h21:   bad_map = (a[23:2] != 0);
          default: bad_map = 1'b1;
        endcase
      end
    endcase
    bad_exec = is_instr && ((a >= 32'hd0000000 && a <= 32'hd0000fff) ||
                            (app && a <= 32'h00001fff));
    in_win = win_en && is_instr && (a >= first) && (a <= last);
    return bad_map || bad_exec || in_win;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic do_reset();
    @(posedge clk);
    reset_n <= 1'b0;
    apb_req <= '0;
    cpu_bus <= '0;
    syscall <= 1'b0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic apb_write(input tk1_pkg::reg_addr_t a, input tk1_pkg::word_t d);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: a, pwdata: d};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_expect(input string name, input tk1_pkg::reg_addr_t a,
                             input tk1_pkg::word_t expected);
    tk1_pkg::word_t d;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: a, pwdata: '0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    d = apb_rsp.prdata;
    @(posedge clk);
    apb_req <= '0;
    check(name, expected, d);
  endtask

  // One valid CPU cycle, returns where force_trap has settled
  task automatic present(input logic is_instr, input tk1_pkg::addr_t a);
    @(posedge clk);
    cpu_bus <= '{valid: 1'b1, instr: is_instr, addr: a};
    @(posedge clk);
    cpu_bus <= '0;
    @(negedge clk);
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin
    logic [31:0] addr, offset, first, last;
    logic        instr, fw_done, sc, win_en;
    reset_n <= 1'b0;
    apb_req <= '0;
    cpu_bus <= '0;
    syscall <= 1'b0;
    do_reset();

    // Identification and LED
    read_expect("name0", tk1_pkg::ADDR_NAME0, 32'h746b3120);
    read_expect("name1", tk1_pkg::ADDR_NAME1, 32'h6d6b6466);
    read_expect("version", tk1_pkg::ADDR_VERSION, 32'h00000005);
    read_expect("led reset", tk1_pkg::ADDR_LED, 32'h6);
    read_expect("app size reset", tk1_pkg::ADDR_APP_SIZE, TB_APP_SIZE);
    read_expect("unmapped", 8'h30, 32'h0);
    apb_write(tk1_pkg::ADDR_LED, 32'h3);
    @(negedge clk);
    check("led pins", 32'h3, {led_r, led_g, led_b});
    read_expect("led readback", tk1_pkg::ADDR_LED, 32'h3);

    // Privileged registers across modes
    apb_write(tk1_pkg::ADDR_APP_START, 32'h40000000);
    apb_write(tk1_pkg::ADDR_APP_SIZE, 32'h00008000);
    read_expect("app start fw", tk1_pkg::ADDR_APP_START, 32'h40000000);
    read_expect("app size fw", tk1_pkg::ADDR_APP_SIZE, 32'h00008000);
    check("app start pins", 32'h40000000, app_start);
    check("app size pins", 32'h00008000, app_size);
    present(1'b1, 32'h40000000);
    check("startup done", 1, fw_startup_done);
    check("app mode on", 1, app_mode);
    apb_write(tk1_pkg::ADDR_APP_START, 32'h00001234);
    read_expect("app start locked", tk1_pkg::ADDR_APP_START, 32'h40000000);
    @(posedge clk);
    syscall <= 1'b1;
    @(negedge clk);
    check("app mode syscall", 0, app_mode);
    apb_write(tk1_pkg::ADDR_APP_START, 32'h40001000);
    read_expect("app start syscall", tk1_pkg::ADDR_APP_START, 32'h40001000);

    // System reset pulse, firmware mode then application mode
    apb_write(tk1_pkg::ADDR_SYSTEM_RESET, 32'h1);
    @(negedge clk);
    check("sys reset high", 1, system_reset);
    @(negedge clk);
    check("sys reset end", 0, system_reset);
    @(posedge clk);
    syscall <= 1'b0;
    apb_write(tk1_pkg::ADDR_SYSTEM_RESET, 32'h1);
    @(negedge clk);
    check("sys reset app 1", 0, system_reset);
    @(negedge clk);
    check("sys reset app 2", 0, system_reset);
    check("no trap so far", 0, force_trap);

    // Window lock and hits
    do_reset();
    apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd1, 32'h40000100);
    apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd2, 32'h400001ff);
    apb_write(tk1_pkg::ADDR_WIN_BASE, 32'h1);
    apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd1, 32'h40000000);
    present(1'b0, 32'h40000150);
    check("window data access", 0, force_trap);
    present(1'b1, 32'h40000080);
    check("window locked bound", 0, force_trap);
    present(1'b1, 32'h40000150);
    check("window fetch", 1, force_trap);

    // Random trap trials
    for (int t = 0; t < NUM_TRIALS; t++) begin
      addr   = next_bits(2) << 30;
      offset = next_bits(30);
      addr   = addr | (offset >> next_bits(5));
      if (addr[31:30] == 2'd3 && next_bits(1)) begin
        addr[29:24] = named_sub(next_bits(3));
      end
      instr   = next_bits(1);
      fw_done = next_bits(1);
      sc      = next_bits(1);
      win_en  = next_bits(1);
      first   = addr - next_bits(3);
      last    = first + next_bits(3);
      do_reset();
      @(posedge clk);
      syscall <= sc;
      if (fw_done) begin
        present(1'b1, 32'h40000000);
      end
      if (win_en) begin
        apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd5, first);
        apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd6, last);
        apb_write(tk1_pkg::ADDR_WIN_BASE + 8'd4, 32'h1);
      end
      @(negedge clk);
      check($sformatf("trial %0d setup", t), 0, force_trap);
      present(instr, addr);
      check($sformatf("trial %0d addr %h", t, addr),
            expected_trap(addr, instr, fw_done & ~sc, win_en, first, last), force_trap);
    end

    if (UUT.u_chk.fail_count != 0) begin
      $display("The assertion checker reported %0d failures", UUT.u_chk.fail_count);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== dv/tk1_chk.sv ====
// tk1 core assertions
`timescale 1ns/1ps

module tk1_chk (
  input logic               clk,
  input logic               reset_n,
  input tk1_pkg::apb_req_t  apb_req,
  input tk1_pkg::apb_rsp_t  apb_rsp,
  input logic               force_trap,
  input logic               system_reset
);

  int fail_count = 0;

  // Trap latch is sticky until reset
  trap_sticky: assert property (@(posedge clk) (reset_n && force_trap) |=> force_trap)
    else begin
      $error("force_trap fell without a reset");
      fail_count++;
    end

  // Reset request is a single-cycle pulse
  reset_pulse: assert property (@(posedge clk) disable iff (!reset_n)
                                system_reset |=> !system_reset)
    else begin
      $error("system_reset stayed high for two cycles");
      fail_count++;
    end

  // No wait states on APB
  ready_phase: assert property (@(posedge clk)
                                apb_rsp.pready == (apb_req.psel && apb_req.penable))
    else begin
      $error("pready does not match the access phase");
      fail_count++;
    end

endmodule

bind tk1_core tk1_chk u_chk (
  .clk          (clk),
  .reset_n      (reset_n),
  .apb_req      (apb_req),
  .apb_rsp      (apb_rsp),
  .force_trap   (force_trap),
  .system_reset (system_reset)
);

// ==== source/tk1_core.sv ====
// tk1 control core top level
`timescale 1ns/1ps

module tk1_core #(
  parameter int             NUM_WINDOWS = 2,
  parameter tk1_pkg::addr_t APP_SIZE    = '0
) (
  input  logic               clk,
  input  logic               reset_n,
  input  tk1_pkg::apb_req_t  apb_req,
  output tk1_pkg::apb_rsp_t  apb_rsp,
  input  tk1_pkg::cpu_bus_t  cpu_bus,
  input  logic               syscall,
  output logic               force_trap,
  output logic               system_reset,
  output logic               app_mode,
  output logic               fw_startup_done,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b,
  output tk1_pkg::addr_t     app_start,
  output tk1_pkg::addr_t     app_size
);

  tk1_pkg::win_wr_t [NUM_WINDOWS-1:0] win_wr;
  logic [NUM_WINDOWS-1:0]             win_hit;
  logic [2:0]                         led;

  tk1_apb_regs #(
    .NUM_WINDOWS (NUM_WINDOWS),
    .APP_SIZE    (APP_SIZE)
  ) u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .app_mode     (app_mode),
    .win_wr       (win_wr),
    .led          (led),
    .app_start    (app_start),
    .app_size     (app_size),
    .system_reset (system_reset)
  );

  // ---------------------------------------------------------------------
  // Execution-prohibit windows
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < NUM_WINDOWS; i++) begin : g_win
    exec_window u_win (
      .clk     (clk),
      .reset_n (reset_n),
      .wr      (win_wr[i]),
      .cpu_bus (cpu_bus),
      .hit     (win_hit[i])
    );
  end

  security_monitor #(
    .NUM_WINDOWS (NUM_WINDOWS)
  ) u_mon (
    .clk             (clk),
    .reset_n         (reset_n),
    .cpu_bus         (cpu_bus),
    .syscall         (syscall),
    .win_hit         (win_hit),
    .app_mode        (app_mode),
    .fw_startup_done (fw_startup_done),
    .force_trap      (force_trap)
  );

  // LED pins straight from the register
  assign led_r = led[2];
  assign led_g = led[1];
  assign led_b = led[0];

endmodule

// ==== source/security_monitor.sv ====
// tk1 security monitor
`timescale 1ns/1ps

module security_monitor #(
  parameter int NUM_WINDOWS = 2
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  tk1_pkg::cpu_bus_t       cpu_bus,
  input  logic                    syscall,
  input  logic [NUM_WINDOWS-1:0]  win_hit,
  output logic                    app_mode,
  output logic                    fw_startup_done,
  output logic                    force_trap
);

  logic fw_startup_done_reg;
  logic fw_startup_done_set;
  logic force_trap_reg;
  logic force_trap_set;
  logic map_violation;
  logic exec_violation;

  // Offset limit per MMIO sub-region
  function automatic logic mmio_violation(input tk1_pkg::addr_t addr);
    tk1_pkg::mmio_sub_e sub;
    sub = tk1_pkg::mmio_sub_e'(addr[29:24]);
    case (sub)
      tk1_pkg::MMIO_TRNG,
      tk1_pkg::MMIO_TIMER,
      tk1_pkg::MMIO_UART,
      tk1_pkg::MMIO_TOUCH,
      tk1_pkg::MMIO_TK1:    return |addr[23:10];
      tk1_pkg::MMIO_UDS:     return |addr[23:5];
      tk1_pkg::MMIO_FW_RAM:  return |addr[23:12];
      tk1_pkg::MMIO_SYSCALL: return |addr[23:2];
      // Gaps between named sub-regions
      default:               return 1'b1;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Privilege tracking
  // ---------------------------------------------------------------------
  // First fetch above ROM ends firmware start-up
  assign fw_startup_done_set = cpu_bus.valid && cpu_bus.instr &&
                               (cpu_bus.addr > tk1_pkg::FW_ROM_LAST);

  assign app_mode        = fw_startup_done_reg & ~syscall;
  assign fw_startup_done = fw_startup_done_reg;

  // ---------------------------------------------------------------------
  // Access checks
  // ---------------------------------------------------------------------
  always_comb begin
    case (cpu_bus.addr[31:30])
      2'd0:    map_violation = |cpu_bus.addr[29:13];
      2'd1:    map_violation = |cpu_bus.addr[29:17];
      2'd2:    map_violation = 1'b1;
      default: map_violation = mmio_violation(cpu_bus.addr);
    endcase
  end

  // No fetches from firmware RAM, nor from ROM once in app mode
  assign exec_violation = cpu_bus.instr &&
    (((cpu_bus.addr >= tk1_pkg::FW_RAM_FIRST) && (cpu_bus.addr <= tk1_pkg::FW_RAM_LAST)) ||
     (app_mode && (cpu_bus.addr <= tk1_pkg::FW_ROM_LAST)));

  assign force_trap_set = (cpu_bus.valid && (map_violation || exec_violation)) || (|win_hit);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      fw_startup_done_reg <= 1'b0;
      force_trap_reg      <= 1'b0;
    end else begin
      if (fw_startup_done_set) begin
        fw_startup_done_reg <= 1'b1;
      end
      // Sticky until reset
      if (force_trap_set) begin
        force_trap_reg <= 1'b1;
      end
    end
  end

  assign force_trap = force_trap_reg;

endmodule

// ==== source/exec_window.sv ====
// Execution-prohibit window
`timescale 1ns/1ps

module exec_window (
  input  logic               clk,
  input  logic               reset_n,
  input  tk1_pkg::win_wr_t   wr,
  input  tk1_pkg::cpu_bus_t  cpu_bus,
  output logic               hit
);

  logic           en_reg;
  tk1_pkg::addr_t first_reg;
  tk1_pkg::addr_t last_reg;

  // Any control write enables, and only reset clears it
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      en_reg <= 1'b0;
    end else if (wr.en_set) begin
      en_reg <= 1'b1;
    end
  end

  // Bounds frozen once the window is locked
  always_ff @(posedge clk) begin
    if (!en_reg) begin
      if (wr.first_we) begin
        first_reg <= wr.data;
      end
      if (wr.last_we) begin
        last_reg <= wr.data;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Hit detection, inclusive range on instruction fetches
  // ---------------------------------------------------------------------
  assign hit = en_reg && cpu_bus.valid && cpu_bus.instr &&
               (cpu_bus.addr >= first_reg) && (cpu_bus.addr <= last_reg);

endmodule

// ==== source/tk1_apb_regs.sv ====
// tk1 APB register block
`timescale 1ns/1ps

module tk1_apb_regs #(
  parameter int             NUM_WINDOWS = 2,
  parameter tk1_pkg::addr_t APP_SIZE    = '0
) (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  tk1_pkg::apb_req_t                    apb_req,
  output tk1_pkg::apb_rsp_t                    apb_rsp,
  input  logic                                 app_mode,
  output tk1_pkg::win_wr_t [NUM_WINDOWS-1:0]   win_wr,
  output logic [2:0]                           led,
  output tk1_pkg::addr_t                       app_start,
  output tk1_pkg::addr_t                       app_size,
  output logic                                 system_reset
);

  // ---------------------------------------------------------------------
  // Transfer decode
  // ---------------------------------------------------------------------
  logic access;
  logic wr_access;
  logic rd_access;

  logic [2:0]     led_reg;
  tk1_pkg::addr_t app_start_reg;
  tk1_pkg::addr_t app_size_reg;
  logic           system_reset_reg;

  logic led_we;
  logic app_start_we;
  logic app_size_we;
  logic system_reset_new;

  tk1_pkg::word_t rdata;

  // Access phase, the only cycle with pready high
  assign access    = apb_req.psel & apb_req.penable;
  assign wr_access = access & apb_req.pwrite;
  assign rd_access = access & ~apb_req.pwrite;

  // Privileged registers only take writes in firmware mode
  assign led_we           = wr_access && (apb_req.paddr == tk1_pkg::ADDR_LED);
  assign app_start_we     = wr_access && !app_mode &&
                            (apb_req.paddr == tk1_pkg::ADDR_APP_START);
  assign app_size_we      = wr_access && !app_mode &&
                            (apb_req.paddr == tk1_pkg::ADDR_APP_SIZE);
  assign system_reset_new = wr_access && !app_mode &&
                            (apb_req.paddr == tk1_pkg::ADDR_SYSTEM_RESET);

  // ---------------------------------------------------------------------
  // Control registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_reg          <= tk1_pkg::LED_RESET;
      app_start_reg    <= '0;
      app_size_reg     <= APP_SIZE;
      system_reset_reg <= 1'b0;
    end else begin
      // Pulse lasts the single cycle after the access phase
      system_reset_reg <= system_reset_new;
      if (led_we) begin
        led_reg <= apb_req.pwdata[2:0];
      end
      if (app_start_we) begin
        app_start_reg <= apb_req.pwdata;
      end
      if (app_size_we) begin
        app_size_reg <= apb_req.pwdata;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Window strobes
  // ---------------------------------------------------------------------
  // Lock is enforced in the window itself
  always_comb begin
    tk1_pkg::reg_addr_t base;
    for (int i = 0; i < NUM_WINDOWS; i++) begin
      base = tk1_pkg::ADDR_WIN_BASE + tk1_pkg::reg_addr_t'(4 * i);
      win_wr[i].en_set   = wr_access && (apb_req.paddr == base);
      win_wr[i].first_we = wr_access && (apb_req.paddr == base + 8'd1);
      win_wr[i].last_we  = wr_access && (apb_req.paddr == base + 8'd2);
      win_wr[i].data     = apb_req.pwdata;
    end
  end

  // ---------------------------------------------------------------------
  // Read mux
  // ---------------------------------------------------------------------
  always_comb begin
    rdata = '0;
    if (rd_access) begin
      case (apb_req.paddr)
        tk1_pkg::ADDR_NAME0:     rdata = tk1_pkg::CORE_NAME0;
        tk1_pkg::ADDR_NAME1:     rdata = tk1_pkg::CORE_NAME1;
        tk1_pkg::ADDR_VERSION:   rdata = tk1_pkg::CORE_VERSION;
        tk1_pkg::ADDR_LED:       rdata = {29'h0, led_reg};
        tk1_pkg::ADDR_APP_START: rdata = app_start_reg;
        tk1_pkg::ADDR_APP_SIZE:  rdata = app_size_reg;
        default:                 rdata = '0;
      endcase
    end
  end

  // No wait states
  assign apb_rsp.prdata = rdata;
  assign apb_rsp.pready = access;

  assign led          = led_reg;
  assign app_start    = app_start_reg;
  assign app_size     = app_size_reg;
  assign system_reset = system_reset_reg;

endmodule

// ==== source/tk1_pkg.sv ====
// tk1 shared definitions
package tk1_pkg;

  // ---------------------------------------------------------------------
  // Basic types
  // ---------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  reg_addr_t;

  // ---------------------------------------------------------------------
  // Register map, word addresses
  // ---------------------------------------------------------------------
  localparam reg_addr_t ADDR_NAME0        = 8'h00;
  localparam reg_addr_t ADDR_NAME1        = 8'h01;
  localparam reg_addr_t ADDR_VERSION      = 8'h02;
  localparam reg_addr_t ADDR_LED          = 8'h09;
  localparam reg_addr_t ADDR_APP_START    = 8'h0c;
  localparam reg_addr_t ADDR_APP_SIZE     = 8'h0d;
  // Window i sits at base + 4*i: ctrl, first, last
  localparam reg_addr_t ADDR_WIN_BASE     = 8'h60;
  localparam reg_addr_t ADDR_SYSTEM_RESET = 8'h70;

  // Identification words, "tk1 " and "mkdf"
  localparam word_t CORE_NAME0   = 32'h746b3120;
  localparam word_t CORE_NAME1   = 32'h6d6b6466;
  localparam word_t CORE_VERSION = 32'h00000005;

  localparam logic [2:0] LED_RESET = 3'h6;

  // Firmware memory bounds
  localparam addr_t FW_ROM_LAST  = 32'h00001fff;
  localparam addr_t FW_RAM_FIRST = 32'hd0000000;
  localparam addr_t FW_RAM_LAST  = 32'hd0000fff;

  // MMIO sub-region, address bits 29:24
  typedef enum logic [5:0] {
    MMIO_TRNG    = 6'h00,
    MMIO_TIMER   = 6'h01,
    MMIO_UDS     = 6'h02,
    MMIO_UART    = 6'h03,
    MMIO_TOUCH   = 6'h04,
    MMIO_FW_RAM  = 6'h10,
    MMIO_SYSCALL = 6'h21,
    MMIO_TK1     = 6'h3f
  } mmio_sub_e;

  // ---------------------------------------------------------------------
  // Bus bundles
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    word_t     pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
  } apb_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  instr;
    addr_t addr;
  } cpu_bus_t;

  // One-cycle write strobes into a single window
  typedef struct packed {
    logic  en_set;
    logic  first_we;
    logic  last_we;
    word_t data;
  } win_wr_t;

endpackage
